//--- design/displayPkg.sv
package displayPkg;

    // ------------------------------------------------------------------------
    // video timing, 640x480 at a 25 MHz class pixel clock
    // ------------------------------------------------------------------------
    localparam int hDisplay   = 640;
    localparam int hFront     = 16;
    localparam int hSync      = 96;
    localparam int hBack      = 48;
    localparam int hTotal     = hDisplay + hFront + hSync + hBack;
    localparam int hCntW      = 10;
    // hsync window starts after the front porch
    localparam int hSyncStart = hDisplay + hFront;
    localparam int hSyncEnd   = hSyncStart + hSync;

    localparam int vDisplay   = 480;
    localparam int vBottom    = 11;
    localparam int vSync      = 2;
    localparam int vTop       = 31;
    localparam int vTotal     = vDisplay + vBottom + vSync + vTop;
    localparam int vCntW      = 10;
    // vsync window starts after the bottom porch
    localparam int vSyncStart = vDisplay + vBottom;
    localparam int vSyncEnd   = vSyncStart + vSync;

    // both syncs active low
    localparam logic syncOn  = 1'b0;
    localparam logic syncOff = 1'b1;

    // ------------------------------------------------------------------------
    // pixel and configuration types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    typedef enum logic [1:0] {
        patSolid,
        patBars,
        patChecker,
        patGradient
    } patternE;

    localparam int tileW = 3;

    typedef struct packed {
        logic             enable;
        patternE          mode;
        rgbT              fg;
        rgbT              bg;
        logic [tileW-1:0] tileShift;
    } cfgT;

    // ------------------------------------------------------------------------
    // register map, word addresses on a 32 bit bus
    // ------------------------------------------------------------------------
    localparam int dataW = 32;
    localparam int adrW  = 4;

    localparam logic [adrW-1:0] regCtrl = adrW'(0);
    localparam logic [adrW-1:0] regFg   = adrW'(1);
    localparam logic [adrW-1:0] regBg   = adrW'(2);
    localparam logic [adrW-1:0] regTile = adrW'(3);

    // ------------------------------------------------------------------------
    // colors and pattern constants
    // ------------------------------------------------------------------------
    localparam rgbT colorWhite = '{8'hff, 8'hff, 8'hff};
    localparam rgbT colorBlack = '{8'h00, 8'h00, 8'h00};

    // eight bars across the active width
    localparam int barWidth = 80;

    localparam rgbT barColors [0:7] = '{
        colorWhite,
        '{8'hff, 8'hff, 8'h00},
        '{8'h00, 8'hff, 8'hff},
        '{8'h00, 8'hff, 8'h00},
        '{8'hff, 8'h00, 8'hff},
        '{8'hff, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'hff},
        colorBlack
    };

    // register contents after reset
    localparam cfgT cfgReset = '{
        enable:    1'b0,
        mode:      patSolid,
        fg:        colorWhite,
        bg:        colorBlack,
        tileShift: tileW'(5)
    };

endpackage

//--- design/timingIf.sv
`timescale 1ns/1ps

interface timingIf;
    import displayPkg::*;

    // active area flag
    logic             de;
    // raw syncs, active low
    logic             hsync;
    logic             vsync;
    // current pixel position
    logic [hCntW-1:0] x;
    logic [vCntW-1:0] y;
    // one clock pulse at the origin
    logic             frameStart;

    // timing generator side
    modport source (output de, hsync, vsync, x, y, frameStart);

    // frame control and pattern side
    modport sink (input de, hsync, vsync, x, y, frameStart);

endinterface

//--- design/displayTiming.sv
`timescale 1ns/1ps

module displayTiming (
    input logic   iClk,
    input logic   rstN,
    timingIf.source tim
);
    import displayPkg::*;

    // ------------------------------------------------------------------------
    // position counters
    // ------------------------------------------------------------------------
    logic [hCntW-1:0] hCnt;
    logic [vCntW-1:0] vCnt;
    logic             hWrap;
    logic             vWrap;

    // last column of a line
    assign hWrap = (hCnt == hCntW'(hTotal - 1));
    // last line of a frame
    assign vWrap = (vCnt == vCntW'(vTotal - 1));

    // x runs every clock
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            hCnt <= '0;
        end else if (hWrap) begin
            hCnt <= '0;
        end else begin
            hCnt <= hCnt + 1'b1;
        end
    end

    // y steps once per line
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            vCnt <= '0;
        end else if (hWrap) begin
            if (vWrap) begin
                vCnt <= '0;
            end else begin
                vCnt <= vCnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // decoded timing
    // ------------------------------------------------------------------------
    logic hActive;
    logic vActive;
    logic hInSync;
    logic vInSync;

    // visible region
    assign hActive = (hCnt < hCntW'(hDisplay));
    assign vActive = (vCnt < vCntW'(vDisplay));

    // sync windows follow the front and bottom porches
    assign hInSync = (hCnt >= hCntW'(hSyncStart)) && (hCnt < hCntW'(hSyncEnd));
    assign vInSync = (vCnt >= vCntW'(vSyncStart)) && (vCnt < vCntW'(vSyncEnd));

    assign tim.de    = hActive && vActive;
    assign tim.hsync = hInSync ? syncOn : syncOff;
    assign tim.vsync = vInSync ? syncOn : syncOff;
    assign tim.x     = hCnt;
    assign tim.y     = vCnt;

    // origin marker, first clock after reset lands here
    assign tim.frameStart = (hCnt == '0) && (vCnt == '0);

endmodule

//--- design/frameCtrl.sv
`timescale 1ns/1ps

module frameCtrl (
    input logic             iClk,
    input logic             rstN,
    timingIf.sink           tim,
    input displayPkg::cfgT  liveCfg,
    output displayPkg::cfgT frameCfg,
    output logic            outEn
);
    import displayPkg::*;

    typedef enum logic [1:0] {
        idle,
        armed,
        run,
        drain
    } stateE;

    stateE state;
    stateE stateNext;
    cfgT   cfgQ;

    // ------------------------------------------------------------------------
    // output FSM
    // ------------------------------------------------------------------------
    always_comb begin
        stateNext = state;
        case (state)
            // enable seen right on the origin goes straight to run
            idle: begin
                if (liveCfg.enable) begin
                    stateNext = tim.frameStart ? run : armed;
                end
            end
            armed: begin
                if (!liveCfg.enable) begin
                    stateNext = idle;
                end else if (tim.frameStart) begin
                    stateNext = run;
                end
            end
            run: begin
                if (!liveCfg.enable) begin
                    stateNext = tim.frameStart ? idle : drain;
                end
            end
            // output off, hold until the frame boundary
            drain: begin
                if (tim.frameStart) begin
                    stateNext = liveCfg.enable ? run : idle;
                end
            end
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            state <= idle;
            cfgQ  <= '0;
        end else begin
            state <= stateNext;
            // configuration snapshot at every origin
            if (tim.frameStart) begin
                cfgQ <= liveCfg;
            end
        end
    end

    // decision for the current pixel, so pixel (0,0) is already covered
    assign outEn = (stateNext == run);

    // live values pass through on the origin pixel itself
    assign frameCfg = tim.frameStart ? liveCfg : cfgQ;

endmodule

//--- design/wbRegs.sv
`timescale 1ns/1ps

module wbRegs (
    input logic                         iClk,
    input logic                         rstN,
    input logic                         cyc,
    input logic                         stb,
    input logic                         we,
    input logic [displayPkg::adrW-1:0]  adr,
    input logic [displayPkg::dataW-1:0] datW,
    output logic [displayPkg::dataW-1:0] datR,
    output logic                        ack,
    output displayPkg::cfgT             liveCfg
);
    import displayPkg::*;

    localparam int colorW = $bits(rgbT);

    cfgT              cfgQ;
    logic             access;
    logic [dataW-1:0] readWord;

    // new request, ack not yet given
    assign access = cyc && stb && !ack;

    // ------------------------------------------------------------------------
    // read decode, unused bits zero
    // ------------------------------------------------------------------------
    always_comb begin
        readWord = '0;
        case (adr)
            regCtrl: begin
                readWord[0]   = cfgQ.enable;
                readWord[2:1] = cfgQ.mode;
            end
            regFg:   readWord[colorW-1:0] = cfgQ.fg;
            regBg:   readWord[colorW-1:0] = cfgQ.bg;
            regTile: readWord[tileW-1:0]  = cfgQ.tileShift;
            default: readWord = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // handshake and register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            ack  <= 1'b0;
            cfgQ <= cfgReset;
        end else begin
            // single clock ack, one cycle after request
            ack <= access;
            if (access && we) begin
                case (adr)
                    regCtrl: begin
                        cfgQ.enable <= datW[0];
                        cfgQ.mode   <= patternE'(datW[2:1]);
                    end
                    regFg:   cfgQ.fg        <= rgbT'(datW[colorW-1:0]);
                    regBg:   cfgQ.bg        <= rgbT'(datW[colorW-1:0]);
                    regTile: cfgQ.tileShift <= datW[tileW-1:0];
                    // unmapped, acked and dropped
                    default: cfgQ <= cfgQ;
                endcase
            end
        end
    end

    // read data presented alongside ack
    always_ff @(posedge iClk) begin
        datR <= access ? readWord : '0;
    end

    assign liveCfg = cfgQ;

endmodule

//--- design/patternGen.sv
`timescale 1ns/1ps

module patternGen (
    input logic             iClk,
    input logic             rstN,
    timingIf.sink           tim,
    input displayPkg::cfgT  frameCfg,
    input logic             outEn,
    output displayPkg::rgbT rgb,
    output logic            de,
    output logic            hsync,
    output logic            vsync
);
    import displayPkg::*;

    logic [2:0]       barIdx;
    logic             tileBit;
    logic             deNext;
    rgbT              color;

    // ------------------------------------------------------------------------
    // pattern math
    // ------------------------------------------------------------------------
    // bar index 0..7 across the active width
    assign barIdx = 3'(tim.x / barWidth);

    // tile parity from the selected position bit
    assign tileBit = tim.x[frameCfg.tileShift] ^ tim.y[frameCfg.tileShift];

    // gated data enable
    assign deNext = tim.de && outEn;

    always_comb begin
        case (frameCfg.mode)
            patSolid: begin
                color = frameCfg.fg;
            end
            patBars: begin
                color = barColors[barIdx];
            end
            patChecker: begin
                color = tileBit ? frameCfg.fg : frameCfg.bg;
            end
            patGradient: begin
                // x and y ramps with blue from fg
                color.red   = tim.x[7:0];
                color.green = tim.y[7:0];
                color.blue  = frameCfg.fg.blue;
            end
            default: begin
                color = frameCfg.fg;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // output stage one clock behind the position
    // ------------------------------------------------------------------------
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            de    <= 1'b0;
            rgb   <= '0;
            hsync <= syncOff;
            vsync <= syncOff;
        end else begin
            de <= deNext;
            // black outside the active area
            rgb   <= deNext ? color : '0;
            hsync <= tim.hsync;
            vsync <= tim.vsync;
        end
    end

endmodule

//--- design/displayTop.sv
`timescale 1ns/1ps

module displayTop (
    input logic                          iClk,
    input logic                          rstN,
    // wishbone classic slave
    input logic                          cyc,
    input logic                          stb,
    input logic                          we,
    input logic [displayPkg::adrW-1:0]   adr,
    input logic [displayPkg::dataW-1:0]  datW,
    output logic [displayPkg::dataW-1:0] datR,
    output logic                         ack,
    // video out
    output logic [23:0]                  rgb,
    output logic                         de,
    output logic                         hsync,
    output logic                         vsync
);
    import displayPkg::*;

    // ------------------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------------------
    cfgT  liveCfg;
    cfgT  frameCfg;
    logic outEn;

    timingIf tim0 ();

    // raster counters
    displayTiming timing0 (
        .iClk (iClk),
        .rstN (rstN),
        .tim  (tim0.source)
    );

    // bus side configuration
    wbRegs regs0 (
        .iClk    (iClk),
        .rstN    (rstN),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datW    (datW),
        .datR    (datR),
        .ack     (ack),
        .liveCfg (liveCfg)
    );

    // frame aligned enable and config
    frameCtrl ctrl0 (
        .iClk     (iClk),
        .rstN     (rstN),
        .tim      (tim0.sink),
        .liveCfg  (liveCfg),
        .frameCfg (frameCfg),
        .outEn    (outEn)
    );

    // pixel stage
    patternGen pattern0 (
        .iClk     (iClk),
        .rstN     (rstN),
        .tim      (tim0.sink),
        .frameCfg (frameCfg),
        .outEn    (outEn),
        .rgb      (rgb),
        .de       (de),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

//--- dv/displayChecker.sv
`timescale 1ns/1ps

module displayChecker (
    input logic        iClk,
    input logic        rstN,
    input logic        cyc,
    input logic        stb,
    input logic        ack,
    input logic [23:0] rgb,
    input logic        de,
    input logic        hsync,
    input logic        vsync
);

    // failed assertion count
    int assertFails = 0;

    // ------------------------------------------------------------------------
    // wishbone handshake
    // ------------------------------------------------------------------------
    // ack is a one clock pulse
    ackPulse: assert property (@(posedge iClk) disable iff (!rstN) ack |=> !ack)
        else begin
            $error("ack held high for more than one clock");
            assertFails++;
        end

    // ack only answers a request seen one clock earlier
    ackAfterReq: assert property (@(posedge iClk) disable iff (!rstN)
        ack |-> $past(cyc && stb))
        else begin
            $error("ack without a cyc and stb request before it");
            assertFails++;
        end

    // ------------------------------------------------------------------------
    // video relations
    // ------------------------------------------------------------------------
    // active pixels never overlap a sync pulse
    deOutsideSync: assert property (@(posedge iClk) disable iff (!rstN)
        de |-> (hsync && vsync))
        else begin
            $error("de high while a sync pulse is active");
            assertFails++;
        end

    // blanked pixels are black
    blankBlack: assert property (@(posedge iClk) disable iff (!rstN)
        !de |-> (rgb == 24'h0))
        else begin
            $error("rgb not zero while de is low");
            assertFails++;
        end

endmodule

bind displayTop displayChecker check0 (.*);

//--- dv/displayTb.sv
`timescale 1ns/1ps

module displayTb;
    import displayPkg::*;

    localparam int frameCycles = hTotal * vTotal;
    localparam int ackWait     = 16;
    localparam     goldenPath  = "dv/displayGolden.txt";

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------
    logic             iClk;
    logic             rstN;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [adrW-1:0]  adr;
    logic [dataW-1:0] datW;
    logic [dataW-1:0] datR;
    logic             ack;
    logic [23:0]      rgb;
    logic             de;
    logic             hsync;
    logic             vsync;

    // bookkeeping
    string testName = "none";
    int    testErrs = 0;
    int    errCnt = 0;
    int    checkCnt = 0;
    int    testCnt = 0;
    int    cycleCnt = 0;
    int    cycleLimit = 0;

    // raster position rebuilt from the outputs
    logic prevDe = 1'b0;
    logic prevHsync = 1'b1;
    logic prevVsync = 1'b1;
    logic deFell;
    logic hsyncFell;
    logic vsyncFell;
    logic pixValid;
    int   colCnt = 0;
    int   rowCnt = 0;
    int   rowLen = 0;
    int   pixX;
    int   pixY;

    displayTop dut0 (
        .iClk  (iClk),
        .rstN  (rstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .datR  (datR),
        .ack   (ack),
        .rgb   (rgb),
        .de    (de),
        .hsync (hsync),
        .vsync (vsync)
    );

    // 8 ns pixel clock
    always #4 iClk = ~iClk;

    // run limit, armed once the golden file is sized
    always @(posedge iClk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
            $display("run stopped at the cycle limit of %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic checkWord(input string what, input logic [dataW-1:0] expected,
                             input logic [dataW-1:0] actual);
        checkCnt++;
        if (actual !== expected) begin
            $display("error %0s %0s: expected %h actual %h", testName, what, expected, actual);
            testErrs++;
            errCnt++;
        end
    endtask

    task automatic checkRgb(input string what, input rgbT expected, input rgbT actual);
        checkCnt++;
        if (actual !== expected) begin
            $display("error %0s %0s: expected %h actual %h", testName, what, expected, actual);
            testErrs++;
            errCnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // one clock of raster tracking, sampled mid cycle
    // ------------------------------------------------------------------------
    task automatic stepClock();
        @(negedge iClk);
        vsyncFell = prevVsync && !vsync;
        hsyncFell = prevHsync && !hsync;
        deFell    = prevDe && !de;
        pixValid  = 1'b0;
        // new frame on vsync, new row when de drops
        if (vsyncFell) begin
            rowCnt = 0;
            colCnt = 0;
        end else if (deFell) begin
            rowLen = colCnt;
            rowCnt++;
            colCnt = 0;
        end
        if (de) begin
            pixX     = colCnt;
            pixY     = rowCnt;
            pixValid = 1'b1;
            colCnt++;
        end
        prevVsync = vsync;
        prevHsync = hsync;
        prevDe    = de;
    endtask

    // stops right after a vsync falling edge
    task automatic waitFrame();
        do begin
            stepClock();
        end while (!vsyncFell);
    endtask

    // ------------------------------------------------------------------------
    // bus master
    // ------------------------------------------------------------------------
    task automatic busAccess(input logic write, input logic [adrW-1:0] a,
                             input logic [dataW-1:0] d, output logic [dataW-1:0] r);
        int waitCnt;
        int idle;
        @(posedge iClk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        adr  <= a;
        datW <= d;
        waitCnt = 0;
        stepClock();
        // hold the request until ack
        while (!ack && waitCnt < ackWait) begin
            stepClock();
            waitCnt++;
        end
        r = datR;
        if (!ack) begin
            $display("test %0s: bus access to address %0h was never acknowledged",
                     testName, a);
            testErrs++;
            errCnt++;
        end
        @(posedge iClk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        idle = $urandom % 4;
        stepClock();
        repeat (idle) stepClock();
    endtask

    // ------------------------------------------------------------------------
    // frame level checks
    // ------------------------------------------------------------------------
    task automatic checkBlank();
        int dePix;
        int hsPulses;
        waitFrame();
        dePix    = 0;
        hsPulses = 0;
        do begin
            stepClock();
            if (de) begin
                dePix++;
            end
            if (hsyncFell) begin
                hsPulses++;
            end
        end while (!vsyncFell);
        checkWord("de pixels while disabled", 0, dePix);
        checkWord("hsync pulses in a frame", vTotal, hsPulses);
    endtask

    task automatic checkLines();
        int rows;
        int shortest;
        int longest;
        waitFrame();
        rows     = 0;
        shortest = hTotal;
        longest  = 0;
        do begin
            stepClock();
            if (deFell) begin
                rows++;
                if (rowLen < shortest) begin
                    shortest = rowLen;
                end
                if (rowLen > longest) begin
                    longest = rowLen;
                end
            end
        end while (!vsyncFell);
        checkWord("active lines", vDisplay, rows);
        checkWord("shortest line", hDisplay, shortest);
        checkWord("longest line", hDisplay, longest);
    endtask

    task automatic samplePixel(input int x, input int y, input rgbT expected);
        logic reached;
        reached = 1'b0;
        do begin
            stepClock();
            if (pixValid && pixX == x && pixY == y) begin
                reached = 1'b1;
            end
        end while (!reached && !vsyncFell);
        if (reached) begin
            checkRgb($sformatf("pixel %0d,%0d", x, y), expected, rgbT'(rgb));
        end else begin
            $display("test %0s: pixel %0d,%0d did not show up before the frame ended",
                     testName, x, y);
            testErrs++;
            errCnt++;
        end
    endtask

    // mid frame hold point
    task automatic waitRow(input int y);
        do begin
            stepClock();
        end while (rowCnt < y && !vsyncFell);
        if (rowCnt < y) begin
            $display("test %0s: row %0d did not show up before the frame ended", testName, y);
            testErrs++;
            errCnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // golden file handling
    // ------------------------------------------------------------------------
    // frames to budget, -1 when the file is missing
    task automatic countFrames(output int frames);
        int    fd;
        string word;
        string rest;
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            frames = -1;
        end else begin
            frames = 0;
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (word == "frame" || word == "blank" || word == "lines") begin
                    // boundary wait plus the frame behind it
                    frames += 2;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runGolden();
        int               fd;
        string            cmd;
        string            rest;
        logic [adrW-1:0]  a;
        logic [dataW-1:0] d;
        logic [dataW-1:0] r;
        int               sampleX;
        int               sampleY;
        logic [23:0]      color;
        fd = $fopen(goldenPath, "r");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.substr(0, 0) == "#") begin
                void'($fgets(rest, fd));
            end else if (cmd == "test") begin
                void'($fscanf(fd, "%s", testName));
                testErrs = 0;
            end else if (cmd == "wr") begin
                void'($fscanf(fd, "%h %h", a, d));
                busAccess(1'b1, a, d, r);
            end else if (cmd == "rd") begin
                void'($fscanf(fd, "%h %h", a, d));
                busAccess(1'b0, a, '0, r);
                checkWord($sformatf("read of address %0h", a), d, r);
            end else if (cmd == "px") begin
                void'($fscanf(fd, "%d %d %h", sampleX, sampleY, color));
                samplePixel(sampleX, sampleY, rgbT'(color));
            end else if (cmd == "row") begin
                void'($fscanf(fd, "%d", sampleY));
                waitRow(sampleY);
            end else if (cmd == "frame") begin
                waitFrame();
            end else if (cmd == "blank") begin
                checkBlank();
            end else if (cmd == "lines") begin
                checkLines();
            end else if (cmd == "end") begin
                testCnt++;
                if (testErrs == 0) begin
                    $display("test %0s ok", testName);
                end else begin
                    $display("test %0s failed with %0d errors", testName, testErrs);
                end
            end else begin
                $display("golden file holds an unknown keyword %0s", cmd);
                errCnt++;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int frames;
        int seedVal;
        iClk = 1'b0;
        rstN = 1'b0;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        adr  = '0;
        datW = '0;
        seedVal = $urandom(32'h1bda);
        countFrames(frames);
        if (frames < 0) begin
            $display("golden file %0s could not be opened", goldenPath);
            errCnt++;
        end else begin
            cycleLimit = (frames + 2) * frameCycles + 1000;
            repeat (3) @(posedge iClk);
            rstN <= 1'b1;
            runGolden();
        end
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testCnt, checkCnt, errCnt, dut0.check0.assertFails);
        if (errCnt == 0 && dut0.check0.assertFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/displayPkg.sv
design/timingIf.sv
design/displayTiming.sv
design/frameCtrl.sv
design/wbRegs.sv
design/patternGen.sv
design/displayTop.sv
dv/displayChecker.sv
dv/displayTb.sv

//--- Bender.yml
package:
  name: display

sources:
  - files:
      - design/displayPkg.sv
      - design/timingIf.sv
      - design/displayTiming.sv
      - design/frameCtrl.sv
      - design/wbRegs.sv
      - design/patternGen.sv
      - design/displayTop.sv
  - target: simulation
    files:
      - dv/displayChecker.sv
      - dv/displayTb.sv

//--- dv/displayGolden.txt
# keyword and arguments per record; adr, data and rgb in hex, x and y in decimal
# test name | wr adr data | rd adr data | px x y rgb | row y | frame | blank | lines | end
test enableGate
blank
wr 0 00000001
lines
end
test regAccess
wr 0 ffffffff
rd 0 00000007
wr 1 ffffffff
rd 1 00ffffff
wr 2 ffffffff
rd 2 00ffffff
wr 3 ffffffff
rd 3 00000007
wr 7 12345678
rd 7 00000000
rd 0 00000007
rd 1 00ffffff
rd 2 00ffffff
rd 3 00000007
end
test solidBars
wr 0 00000001
wr 1 003c9a5e
frame
px 17 5 3c9a5e
px 600 470 3c9a5e
wr 0 00000003
frame
px 0 10 ffffff
px 79 10 ffffff
px 80 10 ffff00
px 399 10 ff00ff
px 400 10 ff0000
px 639 10 000000
end
test checkerGradient
wr 1 00ff0000
wr 2 000000ff
wr 3 00000003
wr 0 00000005
frame
px 7 7 0000ff
px 8 7 ff0000
px 7 8 ff0000
px 8 8 0000ff
wr 1 00112233
wr 0 00000007
frame
px 300 200 2cc833
end
test frameAlign
wr 0 00000003
frame
px 0 50 ffffff
row 100
wr 0 00000005
px 80 300 ffff00
frame
px 80 300 112233
end
